// ==== flist.f ====
design/i2c_pkg.sv
design/eeprom_pkg.sv
design/cmd_fifo.sv
design/i2c_byte_engine.sv
design/eeprom_wr.sv
design/eeprom_top.sv
tests/eeprom_model.sv
tests/eeprom_assertions.sv
tests/eeprom_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module eeprom_tb -f flist.f -o eeprom_sim \
  && ./obj_dir/eeprom_sim | grep "sim passed" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }

// ==== tests/eeprom_tb.sv ====
module eeprom_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import i2c_pkg::*;
  import eeprom_pkg::*;

  localparam int clk_period  = 20;
  localparam int cond_cycles = quarters_per_bit * bit_quarter;  // start or stop
  localparam int byte_cycles = byte_bits * cond_cycles;
  localparam int wr_cycles   = 2 * cond_cycles + 3 * byte_cycles + 5 * 3;
  localparam int rd_cycles   = 3 * cond_cycles + 4 * byte_cycles + 7 * 3;
  localparam int n_wr        = 14;
  localparam int n_rd        = 14;
  localparam int watchdog_cycles = 2 * (n_wr * wr_cycles + n_rd * rd_cycles) + 400;

  logic              clk;
  logic              reset;
  logic              wr;
  logic              rd;
  logic [addr_w-1:0] addr;
  logic [7:0]        wdata;
  logic              full;
  logic              ack;
  logic              nack;
  logic [7:0]        rdata;
  logic              scl;
  logic              sda_drive_low;
  logic              sda_in;
  logic              model_low;

  logic [7:0] mirror [1 << addr_w];
  logic       exp_read [$];
  logic       exp_nack [$];
  logic [7:0] exp_data [$];
  logic       res_nack [$];
  logic [7:0] res_data [$];
  int         errors;
  int         seed;

  assign sda_in = !(sda_drive_low || model_low);  // open drain

  eeprom_top dut (
    .clk(clk), .reset(reset), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
    .full(full), .ack(ack), .nack(nack), .rdata(rdata),
    .scl(scl), .sda_drive_low(sda_drive_low), .sda_in(sda_in)
  );

  eeprom_model u_model (
    .clk(clk), .reset(reset), .scl(scl), .sda_in(sda_in), .sda_drive_low(model_low)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (ack) begin
      res_nack.push_back(nack);
      res_data.push_back(rdata);
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  // one strobe cycle, then the queue level is settled before the next one
  task automatic strobe(input logic is_read, input logic [addr_w-1:0] a, input logic [7:0] d);
    @(negedge clk);
    while (full) @(negedge clk);
    @(posedge clk);
    wr    <= !is_read;
    rd    <= is_read;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
  endtask

  task automatic issue_write(input logic [addr_w-1:0] a, input logic [7:0] d);
    logic blocked;
    blocked = &a[addr_w-1 -: block_w];  // block 7 has no device
    exp_read.push_back(1'b0);
    exp_nack.push_back(blocked);
    exp_data.push_back(8'h00);
    if (!blocked) mirror[a] = d;
    strobe(1'b0, a, d);
  endtask

  task automatic issue_read(input logic [addr_w-1:0] a);
    logic blocked;
    blocked = &a[addr_w-1 -: block_w];
    exp_read.push_back(1'b1);
    exp_nack.push_back(blocked);
    exp_data.push_back(blocked ? 8'h00 : mirror[a]);
    strobe(1'b1, a, 8'h00);
  endtask

  // wait for every outstanding ack and compare in issue order
  task automatic drain(input string name);
    int         waited;
    int         limit;
    logic       is_rd;
    logic       e_nack;
    logic [7:0] e_data;
    logic [7:0] got;
    waited = 0;
    limit  = (exp_read.size() + 1) * rd_cycles * 2;
    while (res_nack.size() < exp_read.size() && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (res_nack.size() < exp_read.size()) begin
      $display("%s: ack never arrived for %0d command(s)", name,
               exp_read.size() - res_nack.size());
      errors++;
    end
    while (exp_read.size() > 0 && res_nack.size() > 0) begin
      is_rd  = exp_read.pop_front();
      e_nack = exp_nack.pop_front();
      e_data = exp_data.pop_front();
      got    = res_data.pop_front();
      check_flag(name, e_nack, res_nack.pop_front());
      if (is_rd && !e_nack) check_data(name, e_data, got);
    end
    if (res_nack.size() > 0) begin
      $display("%s: more acks came back than commands were issued", name);
      errors++;
    end
    exp_read.delete();
    exp_nack.delete();
    exp_data.delete();
    res_nack.delete();
    res_data.delete();
  endtask

  task automatic test_write_read();
    issue_write(11'h123, 8'h5a);
    issue_read(11'h123);
    drain("write_read");
  endtask

  task automatic test_random();
    logic [addr_w-1:0] addrs [8];
    int r;
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      addrs[i] = {3'($unsigned(r) % 7), 8'(r >>> 8)};
      issue_write(addrs[i], 8'($random(seed)));
    end
    for (int i = 7; i >= 0; i--) begin
      issue_read(addrs[i]);
    end
    drain("random");
  endtask

  task automatic test_queueing();
    issue_write(11'h045, 8'hc3);
    issue_write(11'h3a0, 8'h17);
    issue_read(11'h045);
    issue_write(11'h045, 8'h8e);
    issue_read(11'h045);  // must see the second write
    @(negedge clk);
    check_flag("queueing full", 1'b1, full);  // first command already with the sequencer
    drain("queueing");
  endtask

  task automatic test_block7();
    issue_write(11'h742, 8'h99);
    issue_read(11'h742);
    issue_read(11'h042);
    drain("block7");
  endtask

  task automatic test_reset_abort();
    strobe(1'b0, 11'h2aa, 8'h33);
    repeat (100) @(posedge clk);  // mid address byte
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    res_nack.delete();
    res_data.delete();
    @(negedge clk);
    check_flag("reset_abort scl", 1'b1, scl);
    check_flag("reset_abort sda", 1'b1, sda_in);
    check_flag("reset_abort full", 1'b0, full);
    repeat (wr_cycles) @(negedge clk);  // aborted write would be over by now
    if (res_nack.size() != 0) begin
      $display("reset_abort: ack from the aborted command came out after reset");
      errors++;
    end
    issue_read(11'h123);
    drain("reset_abort");
  endtask

  initial begin
    errors = 0;
    seed   = 32'hec03e618;
    for (int i = 0; i < (1 << addr_w); i++) begin
      mirror[i] = 8'hff;
    end
    reset <= 1'b1;
    wr    <= 1'b0;
    rd    <= 1'b0;
    addr  <= '0;
    wdata <= 8'h00;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_write_read();
    test_random();
    test_queueing();
    test_block7();
    test_reset_abort();
    $display("errors %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tests/eeprom_assertions.sv ====
module eeprom_assertions (
  input logic clk,
  input logic reset,
  input logic wr,
  input logic rd,
  input logic full,
  input logic ack,
  input logic nack,
  input logic scl,
  input logic sda_drive_low,
  input logic op_go,
  input logic busy
);
  timeunit 1ns;
  timeprecision 1ps;

  no_dual_strobe: assert property (@(posedge clk) disable iff (reset) !(wr && rd))
    else $error("wr and rd strobed together");

  no_strobe_when_full: assert property (@(posedge clk) disable iff (reset) (wr || rd) |-> !full)
    else $error("command strobe while queue full");

  nack_with_ack: assert property (@(posedge clk) disable iff (reset) nack |-> ack)
    else $error("nack without ack");

  go_only_when_idle: assert property (@(posedge clk) disable iff (reset) op_go |-> !busy)
    else $error("op_go while the byte engine is busy");

  bus_idle_after_reset: assert property (@(posedge clk) reset |=> (scl && !sda_drive_low))
    else $error("bus not idle after reset");

endmodule

bind eeprom_top eeprom_assertions u_assertions (
  .clk(clk), .reset(reset), .wr(wr), .rd(rd), .full(full), .ack(ack), .nack(nack),
  .scl(scl), .sda_drive_low(sda_drive_low), .op_go(op_go), .busy(busy)
);

// ==== tests/eeprom_model.sv ====
module eeprom_model (
  input  logic clk,
  input  logic reset,
  input  logic scl,
  input  logic sda_in,
  output logic sda_drive_low
);
  timeunit 1ns;
  timeprecision 1ps;
  import i2c_pkg::*;
  import eeprom_pkg::*;

  localparam int mem_size = 1792;  // blocks 0 to 6

  typedef enum logic [2:0] {m_idle, m_rx, m_ack, m_tx, m_tx_ack} mode_e;

  logic [7:0]        mem [mem_size];
  mode_e             mode;
  logic              scl_q;
  logic              sda_q;
  logic [3:0]        bit_cnt;
  logic [7:0]        shreg;
  logic [1:0]        byte_idx;
  logic [2:0]        block;
  logic [addr_w-1:0] ptr;
  logic              reading;

  initial begin
    for (int i = 0; i < mem_size; i++) begin
      mem[i] = 8'hff;
    end
  end

  // line oversampled on clk, so edges are seen one cycle late
  always @(posedge clk) begin
    scl_q <= scl;
    sda_q <= sda_in;
    if (reset) begin
      mode          <= m_idle;
      sda_drive_low <= 1'b0;
    end else if (scl_q && scl && sda_q && !sda_in) begin  // start or repeated start
      mode          <= m_rx;
      bit_cnt       <= 4'd0;
      byte_idx      <= 2'd0;
      sda_drive_low <= 1'b0;
    end else if (scl_q && scl && !sda_q && sda_in) begin  // stop
      mode          <= m_idle;
      sda_drive_low <= 1'b0;
    end else if (!scl_q && scl) begin
      if (mode == m_rx && bit_cnt < 4'd8) begin
        shreg   <= {shreg[6:0], sda_in};
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else if (scl_q && !scl) begin
      case (mode)
        m_rx: begin
          if (bit_cnt == 4'd8) begin
            bit_cnt  <= 4'd0;
            byte_idx <= byte_idx + 2'd1;
            mode     <= m_ack;
            sda_drive_low <= 1'b1;
            if (byte_idx == 2'd0) begin
              block   <= shreg[3:1];
              reading <= shreg[0];
              if (shreg[7:4] != dev_code || shreg[3:1] == 3'd7) begin
                mode          <= m_idle;  // not ours, no ack
                sda_drive_low <= 1'b0;
              end
            end else if (byte_idx == 2'd1) begin
              ptr <= {block, shreg};
            end else begin
              mem[ptr] = shreg;
            end
          end
        end
        m_ack: begin
          if (reading) begin
            mode          <= m_tx;
            bit_cnt       <= 4'd0;
            shreg         <= mem[ptr];
            sda_drive_low <= !mem[ptr][7];
          end else begin
            mode          <= m_rx;
            sda_drive_low <= 1'b0;
          end
        end
        m_tx: begin
          if (bit_cnt == 4'd7) begin
            mode          <= m_tx_ack;
            sda_drive_low <= 1'b0;
          end else begin
            bit_cnt       <= bit_cnt + 4'd1;
            sda_drive_low <= !shreg[3'(6 - bit_cnt)];
          end
        end
        m_tx_ack: mode <= m_idle;  // master nack ends the read
        default: ;
      endcase
    end
  end

endmodule

// ==== design/eeprom_top.sv ====
module eeprom_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::addr_w-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic                          full,
  output logic                          ack,
  output logic                          nack,
  output logic [7:0]                    rdata,
  output logic                          scl,
  output logic                          sda_drive_low,
  input  logic                          sda_in
);
  import eeprom_pkg::*;
  import i2c_pkg::*;

  logic              cmd_valid;
  logic              cmd_is_read;
  logic [addr_w-1:0] cmd_addr;
  logic [7:0]        cmd_wdata;
  logic              cmd_pop;
  logic              op_go;
  i2c_op_e           op;
  logic [7:0]        tx_byte;
  logic              op_done;
  logic              busy;  // engine activity, visible to bound checks
  logic [7:0]        rx_byte;
  logic              ack_in;

  cmd_fifo u_fifo (
    .clk(clk), .reset(reset), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
    .full(full), .cmd_valid(cmd_valid), .cmd_is_read(cmd_is_read),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .cmd_pop(cmd_pop)
  );

  eeprom_wr u_seq (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_is_read(cmd_is_read),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .cmd_pop(cmd_pop),
    .op_go(op_go), .op(op), .tx_byte(tx_byte), .op_done(op_done),
    .rx_byte(rx_byte), .ack_in(ack_in), .ack(ack), .nack(nack), .rdata(rdata)
  );

  i2c_byte_engine u_engine (
    .clk(clk), .reset(reset), .op_go(op_go), .op(op), .tx_byte(tx_byte),
    .op_done(op_done), .busy(busy), .rx_byte(rx_byte), .ack_in(ack_in),
    .scl(scl), .sda_drive_low(sda_drive_low), .sda_in(sda_in)
  );

endmodule

// ==== design/eeprom_wr.sv ====
module eeprom_wr (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          cmd_valid,
  input  logic                          cmd_is_read,
  input  logic [eeprom_pkg::addr_w-1:0] cmd_addr,
  input  logic [7:0]                    cmd_wdata,
  output logic                          cmd_pop,
  output logic                          op_go,
  output i2c_pkg::i2c_op_e              op,
  output logic [7:0]                    tx_byte,
  input  logic                          op_done,
  input  logic [7:0]                    rx_byte,
  input  logic                          ack_in,
  output logic                          ack,
  output logic                          nack,
  output logic [7:0]                    rdata
);
  import i2c_pkg::*;
  import eeprom_pkg::*;

  seq_state_e        state;
  seq_state_e        state_nx;
  i2c_op_e           op_nx;
  logic [7:0]        byte_nx;
  logic              go_nx;
  logic              is_read_q;
  logic [addr_w-1:0] addr_q;
  logic [7:0]        wdata_q;
  logic              nack_seen;
  logic              after_byte;
  logic              slave_nack;
  logic [7:0]        ctrl_byte;

  assign ctrl_byte  = {dev_code, addr_q[8 +: block_w], 1'b0};
  // states entered right after a byte went out
  assign after_byte = (state == addr_w_byte) || (state == data_w) || (state == rstart) ||
                      (state == data_r) || (state == stop);
  assign slave_nack = op_done && after_byte && ack_in;

  always_comb begin
    state_nx = state;
    go_nx    = 1'b0;
    op_nx    = op_stop;
    byte_nx  = 8'h00;
    if (state == idle) begin
      if (cmd_valid) begin
        go_nx    = 1'b1;
        op_nx    = op_start;
        state_nx = ctrl_w;
      end
    end else if (op_done) begin
      go_nx = 1'b1;
      case (state)
        ctrl_w: begin
          op_nx    = op_write;
          byte_nx  = ctrl_byte;
          state_nx = addr_w_byte;
        end
        addr_w_byte: begin
          op_nx    = op_write;
          byte_nx  = addr_q[7:0];
          state_nx = is_read_q ? rstart : data_w;
        end
        data_w: begin
          op_nx    = op_write;
          byte_nx  = wdata_q;
          state_nx = stop;
        end
        rstart: begin
          op_nx    = op_start;
          state_nx = ctrl_r;
        end
        ctrl_r: begin
          op_nx    = op_write;
          byte_nx  = {ctrl_byte[7:1], 1'b1};
          state_nx = data_r;
        end
        data_r: begin
          op_nx    = op_read_nack;  // single byte, master nacks it
          state_nx = stop;
        end
        stop: begin
          state_nx = done;
        end
        default: begin
          go_nx    = 1'b0;  // stop finished
          state_nx = idle;
        end
      endcase
      if (slave_nack) begin
        op_nx    = op_stop;
        byte_nx  = 8'h00;
        state_nx = done;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      cmd_pop   <= 1'b0;
      op_go     <= 1'b0;
      ack       <= 1'b0;
      nack      <= 1'b0;
      nack_seen <= 1'b0;
    end else begin
      state   <= state_nx;
      op_go   <= go_nx;
      cmd_pop <= (state == idle) && cmd_valid;
      ack     <= (state == done) && op_done;
      nack    <= (state == done) && op_done && nack_seen;
      if (state == idle) nack_seen <= 1'b0;
      else if (slave_nack) nack_seen <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (go_nx) begin
      op      <= op_nx;
      tx_byte <= byte_nx;
    end
    if ((state == idle) && cmd_valid) begin
      is_read_q <= cmd_is_read;
      addr_q    <= cmd_addr;
      wdata_q   <= cmd_wdata;
    end
    // op_done here belongs to the read byte
    if ((state == stop) && op_done && is_read_q) rdata <= rx_byte;
  end

endmodule

// ==== design/i2c_byte_engine.sv ====
module i2c_byte_engine (
  input  logic             clk,
  input  logic             reset,
  input  logic             op_go,
  input  i2c_pkg::i2c_op_e op,
  input  logic [7:0]       tx_byte,
  output logic             op_done,
  output logic             busy,
  output logic [7:0]       rx_byte,
  output logic             ack_in,
  output logic             scl,
  output logic             sda_drive_low,
  input  logic             sda_in
);
  import i2c_pkg::*;

  i2c_op_e                  cur_op;
  logic [quarter_cnt_w-1:0] qcnt;
  logic [1:0]               phase;    // quarter within the bit
  logic [3:0]               bitn;
  logic [7:0]               shreg;
  logic                     q_end;
  logic                     bit_end;
  logic                     is_byte;
  logic                     at_ack;
  logic                     last_bit;
  logic                     sample;
  logic                     scl_nx;
  logic                     sda_low_nx;

  assign q_end    = (qcnt == quarter_cnt_w'(bit_quarter - 1));
  assign bit_end  = q_end && (phase == 2'(quarters_per_bit - 1));
  assign is_byte  = (cur_op != op_start) && (cur_op != op_stop);
  assign at_ack   = (bitn == 4'(byte_bits - 1));
  assign last_bit = !is_byte || at_ack;
  assign op_done  = busy && bit_end && last_bit;

  // first cycle of the third quarter, mid scl high on the pin
  assign sample = busy && is_byte && (phase == 2'd2) && (qcnt == '0);

  // scl is high in the two middle quarters of every bit
  always_comb begin
    scl_nx     = (phase == 2'd1) || (phase == 2'd2);
    sda_low_nx = 1'b0;
    case (cur_op)
      op_start: begin
        sda_low_nx = phase[1];  // falls while scl high
      end
      op_stop: begin
        scl_nx     = (phase != 2'd0);
        sda_low_nx = !phase[1];  // rises while scl high
      end
      op_write: begin
        sda_low_nx = !at_ack && !shreg[7];
      end
      op_read_ack: begin
        sda_low_nx = at_ack;  // master ack
      end
      default: begin
        sda_low_nx = 1'b0;  // master nack, line left released
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy          <= 1'b0;
      qcnt          <= '0;
      phase         <= '0;
      bitn          <= '0;
      scl           <= 1'b1;
      sda_drive_low <= 1'b0;
    end else if (!busy) begin
      if (op_go) begin
        busy  <= 1'b1;
        qcnt  <= '0;
        phase <= '0;
        bitn  <= '0;
      end
    end else begin
      scl           <= scl_nx;
      sda_drive_low <= sda_low_nx;
      if (q_end) begin
        qcnt  <= '0;
        phase <= phase + 2'd1;
        if (bit_end) begin
          bitn <= bitn + 4'd1;
          if (last_bit) busy <= 1'b0;
        end
      end else begin
        qcnt <= qcnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && op_go) begin
      cur_op <= op;
      shreg  <= tx_byte;
    end else if (busy && bit_end) begin
      shreg <= {shreg[6:0], 1'b0};  // msb first
    end
    if (sample) begin
      if (at_ack) begin
        ack_in <= (cur_op == op_write) && sda_in;  // high means slave nack
      end else begin
        rx_byte <= {rx_byte[6:0], sda_in};
      end
    end
  end

endmodule

// ==== design/cmd_fifo.sv ====
module cmd_fifo (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::addr_w-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic                          full,
  output logic                          cmd_valid,
  output logic                          cmd_is_read,
  output logic [eeprom_pkg::addr_w-1:0] cmd_addr,
  output logic [7:0]                    cmd_wdata,
  input  logic                          cmd_pop
);
  import eeprom_pkg::*;

  logic                 kind_mem [cmd_depth];  // 1 = read
  logic [addr_w-1:0]    addr_mem [cmd_depth];
  logic [7:0]           data_mem [cmd_depth];
  logic [cmd_ptr_w-1:0] wr_ptr;
  logic [cmd_ptr_w-1:0] rd_ptr;
  logic [cmd_cnt_w-1:0] count;
  logic                 push;
  logic                 pop;

  function automatic logic [cmd_ptr_w-1:0] next_ptr(input logic [cmd_ptr_w-1:0] p);
    return (p == cmd_ptr_w'(cmd_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full        = (count == cmd_cnt_w'(cmd_depth));
  assign cmd_valid   = (count != '0);
  assign push        = (wr || rd) && !full;  // strobe while full is dropped
  assign pop         = cmd_pop && cmd_valid;
  assign cmd_is_read = kind_mem[rd_ptr];
  assign cmd_addr    = addr_mem[rd_ptr];
  assign cmd_wdata   = data_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      kind_mem[wr_ptr] <= rd;
      addr_mem[wr_ptr] <= addr;
      data_mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + cmd_cnt_w'(push) - cmd_cnt_w'(pop);
    end
  end

endmodule

// ==== design/eeprom_pkg.sv ====
package eeprom_pkg;

  localparam int addr_w = 11;

  // address bits above the low byte go out as block select
  localparam int block_w = addr_w - 8;

  localparam int cmd_depth = 4;
  localparam int cmd_ptr_w = $clog2(cmd_depth);
  localparam int cmd_cnt_w = $clog2(cmd_depth + 1);

  // each state waits for the previous op_done, then issues its own step
  typedef enum logic [3:0] {
    idle,
    ctrl_w,
    addr_w_byte,
    data_w,
    rstart,
    ctrl_r,
    data_r,
    stop,
    done
  } seq_state_e;

endpackage

// ==== design/i2c_pkg.sv ====
package i2c_pkg;

  // clk cycles per quarter of an scl period
  localparam int bit_quarter = 2;
  localparam int quarters_per_bit = 4;

  // 8 data bits plus the acknowledge slot
  localparam int byte_bits = 9;

  localparam int quarter_cnt_w = $clog2(bit_quarter + 1);

  // device type code, first nibble of every control byte
  localparam logic [3:0] dev_code = 4'b1010;

  // byte engine operations
  typedef enum logic [2:0] {
    op_start,      // also used as repeated start
    op_write,
    op_read_ack,
    op_read_nack,  // last byte of a read
    op_stop
  } i2c_op_e;

endpackage
